//--- rv_ctrl.f
+incdir+.
rv_pkg.sv
rv_decode.sv
rv_execute.sv
rv_result.sv
rv_ctrl.sv
tb_rv_ctrl.sv

//--- run.sh
#!/bin/sh
# Build and run the rv_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f rv_ctrl.f --top-module tb_rv_ctrl -o sim_tb_rv_ctrl
./obj_dir/sim_tb_rv_ctrl > sim.log 2>&1 || true
cat sim.log
if grep -q "Test completed successfully" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// Expected result plus flags for the fields that the ISA defines for this opcode
typedef struct packed {
  logic [31:0] tag;        // Instruction number in the stream
  result_t     res;
  logic        chk_rd;
  logic        chk_sel;
  logic        chk_wb;
  logic        chk_addr;
  logic        chk_store;
  logic        chk_tgt;
  logic        chk_ldx;
} expect_t;

// Sign extend the low bits of v
function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
  logic [31:0] up;
  up = v << (32 - bits);
  return $signed(up) >>> (32 - bits);
endfunction

function automatic logic [31:0] arith_model(input logic [2:0] f3, input logic alt,
                                            input logic is_r, input logic [31:0] a,
                                            input logic [31:0] b);
  case (f3)
    `RV_F3_ADD_SUB: return (is_r && alt) ? a - b : a + b;  // addi ignores bit 30
    `RV_F3_SLL:     return a << b[4:0];
    `RV_F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    `RV_F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
    `RV_F3_XOR:     return a ^ b;
    `RV_F3_SR: begin
      if (alt) begin
        return $signed(a) >>> b[4:0];
      end
      return a >> b[4:0];
    end
    `RV_F3_OR:      return a | b;
    default:        return a & b;
  endcase
endfunction

function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
  case (f3)
    `RV_F3_BEQ:  return a == b;
    `RV_F3_BNE:  return a != b;
    `RV_F3_BLT:  return $signed(a) < $signed(b);
    `RV_F3_BGE:  return $signed(a) >= $signed(b);
    `RV_F3_BLTU: return a < b;
    `RV_F3_BGEU: return a >= b;
    default:     return 1'b0;
  endcase
endfunction

function automatic expect_t model_instr(input instr_in_t in, input logic [31:0] tag);
  expect_t     e;
  logic [31:0] ins;
  logic [4:0]  op;
  logic [2:0]  f3;
  logic        writes;
  e = '0;
  e.tag = tag;
  e.res.valid = in.valid;
  ins = in.instr;
  op = ins[6:2];
  f3 = ins[14:12];
  writes = 1'b0;
  if (!in.valid) begin
    return e;  // Bubble, only the qualified controls matter
  end
  e.chk_sel = 1'b1;
  e.res.wb_sel = WB_ALU;
  e.chk_wb = 1'b1;
  case (op)
    OP_RTYPE: begin
      e.res.wb_data = arith_model(f3, ins[30], 1'b1, in.rs1_data, in.rs2_data);
      writes = 1'b1;
    end
    OP_ITYPE: begin
      e.res.wb_data = arith_model(f3, ins[30], 1'b0, in.rs1_data, sext(32'(ins[31:20]), 12));
      writes = 1'b1;
    end
    OP_LOAD: begin
      e.res.wb_sel = WB_MEM;
      e.chk_wb = 1'b0;  // No load data comes back
      e.res.mem_addr = in.rs1_data + sext(32'(ins[31:20]), 12);
      e.chk_addr = 1'b1;
      e.chk_ldx = 1'b1;
      case (f3)
        3'b000:  e.res.ldx_sel = LDX_LB;
        3'b001:  e.res.ldx_sel = LDX_LH;
        3'b100:  e.res.ldx_sel = LDX_LBU;
        3'b101:  e.res.ldx_sel = LDX_LHU;
        default: e.res.ldx_sel = LDX_LW;
      endcase
      writes = 1'b1;
    end
    OP_STORE: begin
      e.chk_wb = 1'b0;
      e.res.mem_we = 1'b1;
      e.res.mem_addr = in.rs1_data + sext({20'b0, ins[31:25], ins[11:7]}, 12);
      e.res.store_data = in.rs2_data;
      e.chk_addr = 1'b1;
      e.chk_store = 1'b1;
    end
    OP_BRANCH: begin
      e.chk_wb = 1'b0;
      e.res.redirect = branch_model(f3, in.rs1_data, in.rs2_data);
      e.res.target = in.pc + sext({19'b0, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0}, 13);
      e.chk_tgt = 1'b1;
    end
    OP_JAL, OP_JALR: begin
      e.res.wb_sel = WB_PC4;
      e.res.wb_data = in.pc + 32'd4;
      e.res.redirect = 1'b1;
      e.chk_tgt = 1'b1;
      if (op == OP_JAL) begin
        e.res.target = in.pc + sext({11'b0, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0}, 21);
      end else begin
        e.res.target = (in.rs1_data + sext(32'(ins[31:20]), 12)) & 32'hffff_fffe;
      end
      writes = 1'b1;
    end
    OP_AUIPC: begin
      e.res.wb_data = in.pc + {ins[31:12], 12'h000};
      writes = 1'b1;
    end
    OP_LUI: begin
      e.res.wb_data = {ins[31:12], 12'h000};
      writes = 1'b1;
    end
    default: begin
      e.chk_sel = 1'b0;  // Illegal, valid but no enables
      e.chk_wb = 1'b0;
    end
  endcase
  if (writes) begin
    e.res.rd = ins[11:7];
    e.res.rf_we = (ins[11:7] != 5'd0);
    e.chk_rd = 1'b1;
  end
  return e;
endfunction

`endif

//--- tb_rv_ctrl.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module tb_rv_ctrl;
  import rv_pkg::*;
  `include "tb_rv_model.svh"

  localparam int NUM_INSTR   = 2000;
  localparam int CYCLE_LIMIT = NUM_INSTR + 20;

  logic        clk;
  logic        rst;
  instr_in_t   instr_in;
  result_t     res;
  logic [31:0] lfsr;
  int          cycles;
  expect_t     pending[$];  // Expected results in issue order

  rv_ctrl dut0 (
    .clk (clk),
    .rst (rst),
    .in  (instr_in),
    .res (res)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout, run did not end within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $fatal(1);
    end
  end

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [4:0] pick_opcode(input int k);
    case (k % 10)
      0:       return OP_RTYPE;
      1:       return OP_ITYPE;
      2:       return OP_LOAD;
      3:       return OP_STORE;
      4:       return OP_BRANCH;
      5:       return OP_JAL;
      6:       return OP_JALR;
      7:       return OP_AUIPC;
      8:       return OP_LUI;
      default: return 5'b11111;  // Not an RV32I opcode
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic make_instr(output instr_in_t v);
    logic [31:0] r;
    logic [4:0]  op;
    logic [2:0]  f3;
    draw(2, r);
    v.valid = (r[1:0] != 2'b00);  // About 3 in 4
    draw(8, r);
    op = pick_opcode(int'(r[7:0]));
    draw(32, r);
    v.instr = r;
    draw(3, r);
    f3 = r[2:0];
    if (op == OP_BRANCH && f3[2:1] == 2'b01) begin
      f3[1] = 1'b0;  // Skip reserved branch codes
    end
    if (op == OP_LOAD) begin
      case (f3)
        3'd3:    f3 = 3'd2;
        3'd6:    f3 = 3'd4;
        3'd7:    f3 = 3'd5;
        default: ;
      endcase
    end
    v.instr[14:12] = f3;
    v.instr[6:0] = {op, 2'b11};
    if (op == OP_RTYPE || (op == OP_ITYPE && f3[1:0] == 2'b01)) begin
      v.instr[31:25] = {1'b0, v.instr[30], 5'b0};
    end
    draw(32, r);
    v.pc = {r[31:2], 2'b00};
    draw(32, r);
    v.rs1_data = r;
    draw(32, r);
    v.rs2_data = r;
    draw(2, r);
    if (r[1:0] == 2'b00) begin
      v.rs2_data = v.rs1_data;  // Equal operands for beq/bge paths
    end
  endtask

  task automatic compare_result(input expect_t e);
    string t;
    t = $sformatf("instr %0d", e.tag);
    check_value({t, " valid"}, 32'(e.res.valid), 32'(res.valid));
    check_value({t, " rf_we"}, 32'(e.res.rf_we), 32'(res.rf_we));
    check_value({t, " mem_we"}, 32'(e.res.mem_we), 32'(res.mem_we));
    check_value({t, " redirect"}, 32'(e.res.redirect), 32'(res.redirect));
    if (e.chk_rd) check_value({t, " rd"}, 32'(e.res.rd), 32'(res.rd));
    if (e.chk_sel) check_value({t, " wb_sel"}, 32'(e.res.wb_sel), 32'(res.wb_sel));
    if (e.chk_wb) check_value({t, " wb_data"}, e.res.wb_data, res.wb_data);
    if (e.chk_addr) check_value({t, " mem_addr"}, e.res.mem_addr, res.mem_addr);
    if (e.chk_store) check_value({t, " store_data"}, e.res.store_data, res.store_data);
    if (e.chk_tgt) check_value({t, " target"}, e.res.target, res.target);
    if (e.chk_ldx) check_value({t, " ldx_sel"}, 32'(e.res.ldx_sel), 32'(res.ldx_sel));
  endtask

  initial begin
    instr_in_t stim;
    clk = 1'b0;
    rst = 1'b1;
    instr_in = '0;
    cycles = 0;
    lfsr = 32'h3db9;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    check_value("reset valid", 32'd0, 32'(res.valid));
    check_value("reset rf_we", 32'd0, 32'(res.rf_we));
    check_value("reset mem_we", 32'd0, 32'(res.mem_we));
    check_value("reset redirect", 32'd0, 32'(res.redirect));
    for (int n = 0; n < NUM_INSTR + `RV_PIPE_DEPTH; n++) begin
      if (n > 0) begin
        @(posedge clk);
        #1;
      end
      // Result of the instruction driven RV_PIPE_DEPTH cycles ago
      if (n >= `RV_PIPE_DEPTH) begin
        compare_result(pending.pop_front());
      end
      if (n < NUM_INSTR) begin
        make_instr(stim);
        instr_in = stim;
        pending.push_back(model_instr(stim, 32'(n)));
      end else begin
        instr_in = '0;  // Drain with bubbles
      end
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- rv_ctrl.sv
`timescale 1ns/1ns

module rv_ctrl (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::instr_in_t in,
  output rv_pkg::result_t   res
);
  import rv_pkg::*;

  decode_t dec;  // Decode to execute
  exec_t   ex;   // Execute to result

  // Stage 1, edge k+1
  rv_decode u_decode (
    .clk (clk),
    .rst (rst),
    .in  (in),
    .dec (dec)
  );

  // Stage 2, edge k+2
  rv_execute u_execute (
    .clk (clk),
    .rst (rst),
    .dec (dec),
    .ex  (ex)
  );

  // Stage 3, edge k+3
  rv_result u_result (
    .clk (clk),
    .rst (rst),
    .ex  (ex),
    .res (res)
  );

endmodule

//--- rv_result.sv
`timescale 1ns/1ns

module rv_result (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::exec_t   ex,
  output rv_pkg::result_t res
);
  import rv_pkg::*;

  result_t res_d;

  always_comb begin
    res_d.valid      = ex.valid;
    res_d.rd         = ex.rd;
    res_d.wb_sel     = ex.wb_sel;
    res_d.ldx_sel    = ex.ldx_sel;
    res_d.mem_we     = ex.mem_we;
    res_d.mem_addr   = ex.alu_result;  // Loads and stores share the ALU sum
    res_d.store_data = ex.store_data;
    res_d.redirect   = ex.redirect;
    res_d.target     = ex.target;
    // x0 is never written
    res_d.rf_we      = ex.rf_we & (ex.rd != '0);
    // Load data is not returned here, so WB_MEM falls back to the address
    if (ex.wb_sel == WB_PC4) begin
      res_d.wb_data = ex.pc_plus4;
    end else begin
      res_d.wb_data = ex.alu_result;
    end
  end

  always_ff @(posedge clk) begin
    res <= res_d;
    if (rst) begin
      res.valid    <= 1'b0;
      res.rf_we    <= 1'b0;
      res.mem_we   <= 1'b0;
      res.redirect <= 1'b0;
    end
  end

endmodule

//--- rv_execute.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_execute (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::decode_t dec,
  output rv_pkg::exec_t   ex
);
  import rv_pkg::*;

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [4:0]          shamt;
  logic [`RV_XLEN-1:0] alu_out;
  logic                br_eq;
  logic                br_lt;
  logic                br_taken;
  logic [`RV_XLEN-1:0] jalr_sum;
  exec_t               ex_d;

  // Operand select
  always_comb begin
    case (dec.a_sel)
      A_PC:    op_a = dec.pc;
      A_ZERO:  op_a = '0;  // lui
      default: op_a = dec.rs1_data;
    endcase
  end

  assign op_b  = dec.b_imm ? dec.imm : dec.rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:  alu_out = op_a + op_b;
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_AND:  alu_out = op_a & op_b;
      ALU_OR:   alu_out = op_a | op_b;
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_SLL:  alu_out = op_a << shamt;
      ALU_SRL:  alu_out = op_a >> shamt;
      ALU_SRA:  alu_out = $signed(op_a) >>> shamt;
      ALU_SLT:  alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
      default:  alu_out = op_a + op_b;
    endcase
  end

  // Branch compare always on rs1/rs2, independent of operand muxes
  assign br_eq = dec.rs1_data == dec.rs2_data;
  assign br_lt = dec.br_un ? (dec.rs1_data < dec.rs2_data)
                           : ($signed(dec.rs1_data) < $signed(dec.rs2_data));

  always_comb begin
    case (dec.funct3)
      `RV_F3_BEQ:  br_taken = br_eq;
      `RV_F3_BNE:  br_taken = !br_eq;
      `RV_F3_BLT:  br_taken = br_lt;
      `RV_F3_BGE:  br_taken = !br_lt;
      `RV_F3_BLTU: br_taken = br_lt;
      `RV_F3_BGEU: br_taken = !br_lt;
      default:     br_taken = 1'b0;  // Reserved branch codes
    endcase
  end

  assign jalr_sum = dec.rs1_data + dec.imm;

  always_comb begin
    ex_d.valid      = dec.valid;
    ex_d.alu_result = alu_out;
    ex_d.pc_plus4   = dec.pc + `RV_XLEN'd4;
    ex_d.store_data = dec.rs2_data;
    ex_d.rd         = dec.rd;
    ex_d.rf_we      = dec.rf_we;
    ex_d.mem_we     = dec.mem_we;
    ex_d.wb_sel     = dec.wb_sel;
    ex_d.ldx_sel    = dec.ldx_sel;
    ex_d.redirect   = dec.valid & ((dec.is_branch & br_taken) | dec.is_jal | dec.is_jalr);
    if (dec.is_jalr) begin
      ex_d.target = {jalr_sum[`RV_XLEN-1:1], 1'b0};  // Bit 0 cleared per spec
    end else begin
      ex_d.target = dec.pc + dec.imm;
    end
  end

  always_ff @(posedge clk) begin
    ex <= ex_d;
    if (rst) begin
      ex.valid    <= 1'b0;
      ex.rf_we    <= 1'b0;
      ex.mem_we   <= 1'b0;
      ex.redirect <= 1'b0;
    end
  end

endmodule

//--- rv_decode.sv
`timescale 1ns/1ns
`include "rv_consts.svh"

module rv_decode (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::instr_in_t in,
  output rv_pkg::decode_t   dec
);
  import rv_pkg::*;

  opcode_e             opcode;
  logic [2:0]          funct3;
  logic                alt;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_j;
  logic [`RV_XLEN-1:0] imm_u;
  alu_op_e             alu_arith;
  ldx_sel_e            ldx_load;
  decode_t             dec_d;

  assign opcode = opcode_e'(in.instr[6:2]);
  assign funct3 = in.instr[14:12];
  assign alt    = in.instr[`RV_F7_BIT_ALT];

  // Immediate formats, all sign extended from bit 31
  assign imm_i = {{20{in.instr[31]}}, in.instr[31:20]};
  assign imm_s = {{20{in.instr[31]}}, in.instr[31:25], in.instr[11:7]};
  assign imm_b = {{19{in.instr[31]}}, in.instr[31], in.instr[7], in.instr[30:25],
                  in.instr[11:8], 1'b0};
  assign imm_j = {{11{in.instr[31]}}, in.instr[31], in.instr[19:12], in.instr[20],
                  in.instr[30:21], 1'b0};
  assign imm_u = {in.instr[31:12], 12'b0};

  // ALU op for R and I forms; bit 30 only means sub for R-type
  always_comb begin
    case (funct3)
      `RV_F3_ADD_SUB: alu_arith = (opcode == OP_RTYPE && alt) ? ALU_SUB : ALU_ADD;
      `RV_F3_SLL:     alu_arith = ALU_SLL;
      `RV_F3_SLT:     alu_arith = ALU_SLT;
      `RV_F3_SLTU:    alu_arith = ALU_SLTU;
      `RV_F3_XOR:     alu_arith = ALU_XOR;
      `RV_F3_SR:      alu_arith = alt ? ALU_SRA : ALU_SRL;
      `RV_F3_OR:      alu_arith = ALU_OR;
      `RV_F3_AND:     alu_arith = ALU_AND;
      default:        alu_arith = ALU_ADD;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  ldx_load = LDX_LB;
      3'b001:  ldx_load = LDX_LH;
      3'b100:  ldx_load = LDX_LBU;
      3'b101:  ldx_load = LDX_LHU;
      default: ldx_load = LDX_LW;  // lw and reserved codes
    endcase
  end

  always_comb begin
    dec_d.valid     = in.valid;
    dec_d.pc        = in.pc;
    dec_d.rs1_data  = in.rs1_data;
    dec_d.rs2_data  = in.rs2_data;
    dec_d.funct3    = funct3;
    dec_d.rd        = in.instr[11:7];
    dec_d.imm       = imm_i;
    dec_d.alu_op    = ALU_ADD;
    dec_d.a_sel     = A_RS1;
    dec_d.b_imm     = 1'b0;
    dec_d.is_branch = 1'b0;
    dec_d.is_jal    = 1'b0;
    dec_d.is_jalr   = 1'b0;
    dec_d.br_un     = 1'b0;
    dec_d.rf_we     = 1'b0;
    dec_d.mem_we    = 1'b0;
    dec_d.wb_sel    = WB_ALU;
    dec_d.ldx_sel   = LDX_LW;
    case (opcode)
      OP_RTYPE: begin
        dec_d.alu_op = alu_arith;
        dec_d.rf_we  = 1'b1;
      end
      OP_ITYPE: begin
        dec_d.alu_op = alu_arith;
        dec_d.b_imm  = 1'b1;
        dec_d.rf_we  = 1'b1;
      end
      OP_LOAD: begin
        dec_d.b_imm   = 1'b1;
        dec_d.rf_we   = 1'b1;
        dec_d.wb_sel  = WB_MEM;
        dec_d.ldx_sel = ldx_load;
      end
      OP_STORE: begin
        dec_d.imm    = imm_s;
        dec_d.b_imm  = 1'b1;
        dec_d.mem_we = 1'b1;
      end
      OP_BRANCH: begin
        dec_d.imm       = imm_b;
        dec_d.is_branch = 1'b1;
        dec_d.br_un     = (funct3 == `RV_F3_BLTU) || (funct3 == `RV_F3_BGEU);
      end
      OP_JAL: begin
        dec_d.imm    = imm_j;
        dec_d.b_imm  = 1'b1;
        dec_d.is_jal = 1'b1;
        dec_d.rf_we  = 1'b1;
        dec_d.wb_sel = WB_PC4;
      end
      OP_JALR: begin
        dec_d.b_imm   = 1'b1;
        dec_d.is_jalr = 1'b1;
        dec_d.rf_we   = 1'b1;
        dec_d.wb_sel  = WB_PC4;
      end
      OP_AUIPC: begin
        dec_d.imm   = imm_u;
        dec_d.a_sel = A_PC;
        dec_d.b_imm = 1'b1;
        dec_d.rf_we = 1'b1;
      end
      OP_LUI: begin
        dec_d.imm   = imm_u;
        dec_d.a_sel = A_ZERO;
        dec_d.b_imm = 1'b1;
        dec_d.rf_we = 1'b1;
      end
      default: ;  // Unknown opcode, enables stay clear
    endcase
    // Bubbles carry no side effects
    dec_d.rf_we  = dec_d.rf_we & in.valid;
    dec_d.mem_we = dec_d.mem_we & in.valid;
  end

  always_ff @(posedge clk) begin
    dec <= dec_d;
    if (rst) begin
      dec.valid     <= 1'b0;
      dec.rf_we     <= 1'b0;
      dec.mem_we    <= 1'b0;
      dec.is_branch <= 1'b0;
      dec.is_jal    <= 1'b0;
      dec.is_jalr   <= 1'b0;
    end
  end

endmodule

//--- rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

  // Major opcode, instr[6:2]
  typedef enum logic [4:0] {
    OP_LOAD   = 5'b00000,
    OP_ITYPE  = 5'b00100,
    OP_AUIPC  = 5'b00101,
    OP_STORE  = 5'b01000,
    OP_RTYPE  = 5'b01100,
    OP_LUI    = 5'b01101,
    OP_BRANCH = 5'b11000,
    OP_JALR   = 5'b11001,
    OP_JAL    = 5'b11011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_MEM = 2'd0,
    WB_ALU = 2'd1,
    WB_PC4 = 2'd2
  } wb_sel_e;

  // Load extension select
  typedef enum logic [2:0] {
    LDX_LW  = 3'd0,
    LDX_LHU = 3'd1,
    LDX_LH  = 3'd2,
    LDX_LBU = 3'd3,
    LDX_LB  = 3'd4
  } ldx_sel_e;

  typedef enum logic [1:0] {
    A_RS1  = 2'd0,
    A_PC   = 2'd1,
    A_ZERO = 2'd2
  } a_sel_e;

  typedef struct packed {
    logic                valid;
    logic [31:0]         instr;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
  } instr_in_t;

  typedef struct packed {
    logic                  valid;
    logic [`RV_XLEN-1:0]   pc;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;
    logic [`RV_XLEN-1:0]   imm;
    alu_op_e               alu_op;
    a_sel_e                a_sel;
    logic                  b_imm;      // Operand B from imm, else rs2
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  br_un;
    logic [2:0]            funct3;
    logic [`RV_REG_AW-1:0] rd;
    logic                  rf_we;
    logic                  mem_we;
    wb_sel_e               wb_sel;
    ldx_sel_e              ldx_sel;
  } decode_t;

  typedef struct packed {
    logic                  valid;
    logic [`RV_XLEN-1:0]   alu_result;
    logic [`RV_XLEN-1:0]   pc_plus4;
    logic [`RV_XLEN-1:0]   store_data;
    logic [`RV_REG_AW-1:0] rd;
    logic                  rf_we;
    logic                  mem_we;
    wb_sel_e               wb_sel;
    ldx_sel_e              ldx_sel;
    logic                  redirect;
    logic [`RV_XLEN-1:0]   target;
  } exec_t;

  typedef struct packed {
    logic                  valid;
    logic                  rf_we;
    logic [`RV_REG_AW-1:0] rd;
    wb_sel_e               wb_sel;
    ldx_sel_e              ldx_sel;
    logic [`RV_XLEN-1:0]   wb_data;
    logic                  mem_we;
    logic [`RV_XLEN-1:0]   mem_addr;
    logic [`RV_XLEN-1:0]   store_data;
    logic                  redirect;
    logic [`RV_XLEN-1:0]   target;
  } result_t;

endpackage

//--- rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath widths
`define RV_XLEN   32
`define RV_REG_AW 5

// Arithmetic funct3, shared by R and I forms
`define RV_F3_ADD_SUB 3'b000
`define RV_F3_SLL     3'b001
`define RV_F3_SLT     3'b010
`define RV_F3_SLTU    3'b011
`define RV_F3_XOR     3'b100
`define RV_F3_SR      3'b101  // srl/sra, picked by bit 30
`define RV_F3_OR      3'b110
`define RV_F3_AND     3'b111

// Branch funct3
`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

// Instruction bit that turns add into sub and srl into sra
`define RV_F7_BIT_ALT 30

// Edges from input sample to result
`define RV_PIPE_DEPTH 3

`endif
